// File: project.f
+incdir+verification
rtl/pdp8Package.sv
rtl/coreCycleIf.sv
rtl/coreMemory.sv
rtl/operateUnit.sv
rtl/majorStateSequencer.sv
rtl/pdp8Core.sv
verification/pdp8CoreTb.sv

// File: Bender.yml
package:
  name: pdp8_core

sources:
  - files:
      - rtl/pdp8Package.sv
      - rtl/coreCycleIf.sv
      - rtl/coreMemory.sv
      - rtl/operateUnit.sv
      - rtl/majorStateSequencer.sv
      - rtl/pdp8Core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pdp8CoreTb.sv

// File: verification/pdp8RefModel.svh
/* reference interpreter for the kept PDP-8 instruction set, plus the stimulus LFSR
   included inside the testbench module, which supplies word_t and the package constants */
`ifndef PDP8_REF_MODEL_SVH
`define PDP8_REF_MODEL_SVH

word_t       refMem [CORE_DEPTH];   // shadow core
word_t       refAcc, refPc, refSwitch;
logic        refLink;
int          refCycles;             // memory cycles, console and program
logic [15:0] lfsrState = 16'd19;

// galois lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

function automatic word_t randomWord();
    word_t value;
    value = '0;
    for (int i = 0; i < WORD_WIDTH; i++) begin
        lfsrState = lfsrStep(lfsrState);    // one step per bit
        value     = {value[WORD_WIDTH-2:0], lfsrState[0]};
    end
    return value;
endfunction

// group 1 in order: clear, complement, increment, rotate
function automatic void refGroup1(input word_t ir);
    logic [12:0] r;
    if (ir[7]) refAcc = '0;
    if (ir[6]) refLink = 1'b0;
    if (ir[5]) refAcc = ~refAcc;
    if (ir[4]) refLink = ~refLink;
    r = {refLink, refAcc} + 13'(ir[0]);     // carry out of AC flips link
    if (ir[3] != ir[2]) begin
        for (int n = 0; n < (ir[1] ? 2 : 1); n++)
            r = ir[3] ? {r[0], r[12:1]} : {r[11:0], r[12]};
    end else if (!ir[3] && ir[1]) begin
        r = {r[12], r[5:0], r[11:6]};       // byte swap
    end
    {refLink, refAcc} = r;
endfunction

// one instruction, returns 1 on HLT
function automatic logic refStep();
    word_t       ir, ea;
    logic [12:0] sum;
    logic        skip;
    ir        = refMem[refPc];
    ea        = {ir[7] ? refPc[11:7] : 5'b0, ir[6:0]};
    refPc     = refPc + 1'b1;
    refCycles = refCycles + 1;              // fetch
    if (ir[11:9] < 3'd6 && ir[8]) begin
        refCycles = refCycles + 1;          // defer
        if (ea[11:3] == AUTO_INDEX_BASE[11:3]) refMem[ea] = refMem[ea] + 1'b1;
        ea = refMem[ea];
    end
    if (ir[11:9] < 3'd5) refCycles = refCycles + 1;   // execute
    case (ir[11:9])
        3'd0: refAcc = refAcc & refMem[ea];
        3'd1: begin
            sum     = {1'b0, refAcc} + {1'b0, refMem[ea]};
            refAcc  = sum[11:0];
            refLink = refLink ^ sum[12];
        end
        3'd2: begin
            refMem[ea] = refMem[ea] + 1'b1;
            if (refMem[ea] == '0) refPc = refPc + 1'b1;
        end
        3'd3: begin
            refMem[ea] = refAcc;
            refAcc     = '0;
        end
        3'd4: begin
            refMem[ea] = refPc;             // return address
            refPc      = ea + 1'b1;
        end
        3'd5: refPc = ea;
        3'd6: ;                             // IOT, nothing attached
        default: begin
            if (!ir[8]) begin
                refGroup1(ir);
            end else if (!ir[0]) begin
                skip = (ir[6] & refAcc[11]) | (ir[5] & (refAcc == '0)) | (ir[4] & refLink);
                if (ir[3]) skip = !skip;
                if (ir[7]) refAcc = '0;
                if (ir[2]) refAcc = refAcc | refSwitch;
                if (skip) refPc = refPc + 1'b1;
                return ir[1];
            end
        end
    endcase
    return 1'b0;
endfunction
`endif

// File: verification/pdp8CoreTb.sv
/* testbench for pdp8Core driven through the console port and checked
   against an included reference model; programs must end in HLT within 2000 instructions */
`timescale 1ns/1ps
`default_nettype none

module pdp8CoreTb;
    import pdp8Package::*;

    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_CLOCKS = READ_CYCLES + WRITE_CYCLES + 4;   // one core cycle

    logic        CLOCK, RESET, i_cmdValid, o_cmdReady, o_run, o_link;
    consoleCmd_e i_cmdCode;
    word_t       i_switchReg, o_acc, o_pc, o_ma, o_mb;
    word_t       expAcc, expPc, expMa, expMb;
    logic        expLink, chkAcc, chkLink, chkPc, chkMa, chkMb, chkIdle;
    int          valueErrors, otherErrors, clocks, cmdCount;

    `include "pdp8RefModel.svh"

    pdp8Core DUT (
        .CLOCK (CLOCK), .RESET (RESET), .i_cmdValid (i_cmdValid), .i_cmdCode (i_cmdCode),
        .i_switchReg (i_switchReg), .o_cmdReady (o_cmdReady), .o_run (o_run),
        .o_acc (o_acc), .o_link (o_link), .o_pc (o_pc), .o_ma (o_ma), .o_mb (o_mb)
    );

    initial begin
        CLOCK = 1'b0;
        forever #10 CLOCK = ~CLOCK;
    end

    // budget grows as the model predicts the work
    function automatic int cycleLimit();
        return RESET_CYCLES + refCycles * CYCLE_CLOCKS + cmdCount * 4 + 500;
    endfunction

    always @(posedge CLOCK) begin
        clocks <= clocks + 1;
        if (clocks > cycleLimit()) begin
            $display("timeout after %0d clocks, core never returned to the console", clocks);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // checking

    assert property (@(posedge CLOCK) chkAcc |-> o_acc == expAcc)
        else begin
            valueErrors++;
            $display("[FAIL] o_acc expected %h actual %h", expAcc, $sampled(o_acc));
        end
    assert property (@(posedge CLOCK) chkLink |-> o_link == expLink)
        else begin
            valueErrors++;
            $display("[FAIL] o_link expected %h actual %h", expLink, $sampled(o_link));
        end
    assert property (@(posedge CLOCK) chkPc |-> o_pc == expPc)
        else begin
            valueErrors++;
            $display("[FAIL] o_pc expected %h actual %h", expPc, $sampled(o_pc));
        end
    assert property (@(posedge CLOCK) chkMa |-> o_ma == expMa)
        else begin
            valueErrors++;
            $display("[FAIL] o_ma expected %h actual %h", expMa, $sampled(o_ma));
        end
    assert property (@(posedge CLOCK) chkMb |-> o_mb == expMb)
        else begin
            valueErrors++;
            $display("[FAIL] o_mb expected %h actual %h", expMb, $sampled(o_mb));
        end
    assert property (@(posedge CLOCK) chkIdle |-> !o_run && o_cmdReady)
        else begin
            otherErrors++;
            $display("core not halted and idle at a check");
        end
    // a held command must wait while the core runs
    assert property (@(posedge CLOCK) disable iff (RESET) o_run |-> !o_cmdReady)
        else begin
            otherErrors++;
            $display("command port ready while the core runs");
        end

    ////////////////////////////////////////
    // console helpers

    task automatic sendCmd(input consoleCmd_e cmd, input word_t sw);
        @(posedge CLOCK);
        i_cmdValid  <= 1'b1;
        i_cmdCode   <= cmd;
        i_switchReg <= sw;              // held afterwards since OSR reads it live
        do @(negedge CLOCK); while (!o_cmdReady);
        @(posedge CLOCK);               // taken on this edge
        i_cmdValid <= 1'b0;
        cmdCount++;
    endtask

    task automatic waitIdle();
        do @(negedge CLOCK); while (!o_cmdReady);
    endtask

    task automatic checkState(input logic all);    // all low checks pc only
        @(posedge CLOCK);
        expAcc  <= refAcc;
        expLink <= refLink;
        expPc   <= refPc;
        expMa   <= refPc;
        chkAcc  <= all;
        chkLink <= all;
        chkPc   <= 1'b1;
        chkMa   <= all;
        chkIdle <= 1'b1;
        @(posedge CLOCK);
        {chkAcc, chkLink, chkPc, chkMa, chkIdle} <= '0;
    endtask

    task automatic loadAddress(input word_t address);
        sendCmd(CMD_LOAD_ADDRESS, address);
        waitIdle();
        refPc = address;
    endtask

    task automatic deposit(input word_t value);
        refCycles++;
        sendCmd(CMD_DEPOSIT, value);
        waitIdle();
        refMem[refPc] = value;
        refPc         = refPc + 1'b1;
    endtask

    task automatic examine();
        refCycles++;
        sendCmd(CMD_EXAMINE, '0);
        waitIdle();
        @(posedge CLOCK);
        expMb <= refMem[refPc];
        expMa <= refPc;                 // address of the examined word
        chkMb <= 1'b1;
        chkMa <= 1'b1;
        @(posedge CLOCK);
        chkMb <= 1'b0;
        chkMa <= 1'b0;
        refPc = refPc + 1'b1;
    endtask

    task automatic depositWords(input word_t address, input word_t words[$]);
        loadAddress(address);
        foreach (words[i]) deposit(words[i]);
    endtask

    task automatic refRun(input logic clear);
        int steps;
        steps = 0;
        if (clear) begin
            refAcc  = '0;               // START clears AC and link
            refLink = 1'b0;
        end
        while (!refStep() && steps < 2000) steps++;
        if (steps >= 2000) begin
            otherErrors++;
            $display("reference model never reached HLT");
        end
    endtask

    task automatic startRun(input word_t address, input word_t sw);
        loadAddress(address);
        refSwitch = sw;
        refRun(1'b1);
        sendCmd(CMD_START, sw);
        waitIdle();                     // until HLT
        checkState(1'b1);
    endtask

    ////////////////////////////////////////
    // stimulus

    initial begin
        RESET = 1'b1;
        {i_cmdValid, chkAcc, chkLink, chkPc, chkMa, chkMb, chkIdle, expLink} = '0;
        i_cmdCode   = CMD_LOAD_ADDRESS;
        i_switchReg = '0;
        {expAcc, expPc, expMa, expMb} = '0;
        {valueErrors, otherErrors, clocks, cmdCount, refCycles} = '0;
        {refAcc, refPc, refSwitch, refLink} = '0;
        repeat (RESET_CYCLES) @(posedge CLOCK);
        RESET <= 1'b0;
        checkState(1'b1);               // reset values

        // deposit with auto-advance and read the words back
        loadAddress(12'o1000);
        repeat (8) begin
            deposit(randomWord());
            checkState(1'b0);
        end
        loadAddress(12'o1000);
        repeat (8) examine();

        // TAD AND ISZ DCA where the first ISZ wraps and skips the HLT
        depositWords(12'o0200, '{12'o7300, 12'o1220, 12'o1221, 12'o0222, 12'o2223,
                                 12'o7402, 12'o2224, 12'o3225, 12'o1220, 12'o7402});
        depositWords(12'o0220, '{randomWord(), randomWord(), randomWord(), 12'o7777,
                                 randomWord(), 12'o0000});
        startRun(12'o0200, '0);
        loadAddress(12'o0225);
        examine();

        // JMS I through 0010 and return by JMP I
        depositWords(12'o0010, '{12'o0317});
        depositWords(12'o0300, '{12'o7300, 12'o4410, 12'o7402});
        depositWords(12'o0320, '{12'o0000, 12'o7001, 12'o5720});
        startRun(12'o0300, '0);
        loadAddress(12'o0010);
        examine();
        loadAddress(12'o0320);
        examine();

        // rotates and CMA IAC, then skips of both senses and OSR
        depositWords(12'o0400, '{12'o7300, 12'o1240, 12'o7004, 12'o7012, 12'o7002, 12'o7041,
                                 12'o7110, 12'o7006, 12'o7500, 12'o7001, 12'o7440, 12'o7020,
                                 12'o7420, 12'o7001, 12'o7510, 12'o7040, 12'o7450, 12'o7001,
                                 12'o7430, 12'o7020, 12'o7404, 12'o7402});
        repeat (4) begin
            depositWords(12'o0440, '{randomWord()});
            startRun(12'o0400, randomWord());
        end

        // CONTINUE is held during the run and taken after HLT
        depositWords(12'o0500, '{12'o7301, 12'o7402, 12'o7001, 12'o7402});
        loadAddress(12'o0500);
        refSwitch = '0;
        refRun(1'b1);
        refRun(1'b0);
        sendCmd(CMD_START, '0);
        sendCmd(CMD_CONTINUE, '0);      // waits out the first run
        waitIdle();
        checkState(1'b1);

        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/pdp8Core.sv
/* PDP-8/L-like core with local memory and a halted-mode console port
   no IO bus, interrupts or DMA */
`timescale 1ns/1ps
`default_nettype none

module pdp8Core (
    input  logic                     CLOCK,
    input  logic                     RESET,
    input  logic                     i_cmdValid,
    input  pdp8Package::consoleCmd_e i_cmdCode,
    input  pdp8Package::word_t       i_switchReg,
    output logic                     o_cmdReady,
    output logic                     o_run,
    output pdp8Package::word_t       o_acc,
    output logic                     o_link,
    output pdp8Package::word_t       o_pc,
    output pdp8Package::word_t       o_ma,
    output pdp8Package::word_t       o_mb
);
    import pdp8Package::*;

    coreCycleIf core ();            // sequencer to memory cycle

    word_t instruction, oprAcc, memRefAcc;
    logic  oprLink, memRefLink, skip;

    majorStateSequencer seqUnit (
        .CLOCK         (CLOCK),
        .RESET         (RESET),
        .i_cmdValid    (i_cmdValid),
        .i_cmdCode     (i_cmdCode),
        .i_switchReg   (i_switchReg),
        .i_oprAcc      (oprAcc),
        .i_memRefAcc   (memRefAcc),
        .i_oprLink     (oprLink),
        .i_memRefLink  (memRefLink),
        .i_skip        (skip),
        .i_core        (core.sequencer),
        .o_cmdReady    (o_cmdReady),
        .o_run         (o_run),
        .o_link        (o_link),
        .o_acc         (o_acc),
        .o_pc          (o_pc),
        .o_ma          (o_ma),
        .o_mb          (o_mb),
        .o_instruction (instruction)
    );

    // OSR reads the live switches
    operateUnit opUnit (
        .i_instruction (instruction),
        .i_acc         (o_acc),
        .i_memData     (o_mb),
        .i_switchReg   (i_switchReg),
        .i_link        (o_link),
        .o_oprAcc      (oprAcc),
        .o_memRefAcc   (memRefAcc),
        .o_oprLink     (oprLink),
        .o_memRefLink  (memRefLink),
        .o_skip        (skip)
    );

    coreMemory coreMem (
        .CLOCK  (CLOCK),
        .RESET  (RESET),
        .i_core (core.memory)
    );

endmodule

`default_nettype wire

// File: rtl/majorStateSequencer.sv
/* major/time state machine with AC, L, PC, MA, MB, IR and run flip-flop
   console commands are taken only when halted and idle; IOT runs as a plain fetch */
`timescale 1ns/1ps
`default_nettype none

module majorStateSequencer (
    input  logic                     CLOCK,
    input  logic                     RESET,
    input  logic                     i_cmdValid,
    input  pdp8Package::consoleCmd_e i_cmdCode,
    input  pdp8Package::word_t       i_switchReg,
    input  pdp8Package::word_t       i_oprAcc,
    input  pdp8Package::word_t       i_memRefAcc,
    input  logic                     i_oprLink,
    input  logic                     i_memRefLink,
    input  logic                     i_skip,
    coreCycleIf.sequencer            i_core,
    output logic                     o_cmdReady,
    output logic                     o_run,
    output logic                     o_link,
    output pdp8Package::word_t       o_acc,
    output pdp8Package::word_t       o_pc,
    output pdp8Package::word_t       o_ma,
    output pdp8Package::word_t       o_mb,
    output pdp8Package::word_t       o_instruction
);
    import pdp8Package::*;

    majorState_e majorState;
    timeState_e  timeState;
    word_t       acc, pc, ma, mb, instruction;
    word_t       switchLatch;    // switches sampled at command accept
    logic        link, run;

    opcode_e opcode;
    word_t   effAddr, nextPc;
    logic    cmdTaken, autoIndex, isHalt;

    assign opcode    = opcode_e'(instruction[11:9]);
    assign effAddr   = {instruction[7] ? ma[11:7] : 5'b0, instruction[6:0]};  // page zero or current
    assign autoIndex = (ma[11:3] == AUTO_INDEX_BASE[11:3]);
    assign isHalt    = instruction[8] & ~instruction[0] & instruction[1];   // group 2 HLT
    assign nextPc    = pc + word_t'(i_skip);

    assign o_cmdReady = ~run & (timeState == TS_IDLE);
    assign cmdTaken   = i_cmdValid & o_cmdReady;

    assign i_core.address   = ma;
    assign i_core.writeData = mb;

    assign o_run         = run;
    assign o_link        = link;
    assign o_acc         = acc;
    assign o_pc          = pc;
    assign o_ma          = ma;
    assign o_mb          = mb;
    assign o_instruction = instruction;

    always_ff @(posedge CLOCK) begin
        if (cmdTaken) switchLatch <= i_switchReg;
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            majorState        <= MS_START;
            timeState         <= TS_IDLE;
            acc               <= '0;
            link              <= 1'b0;
            pc                <= '0;
            ma                <= '0;
            mb                <= '0;
            instruction       <= '0;
            run               <= 1'b0;
            i_core.startValid <= 1'b0;
            i_core.writeValid <= 1'b0;
        end else begin
            case (timeState)
                ////////////////////////////////////////
                // idle state takes a console command or starts the next cycle
                TS_IDLE: begin
                    if (run) begin
                        if (majorState == MS_START) begin   // begin a fetch
                            ma         <= pc;
                            pc         <= pc + 1'b1;
                            majorState <= MS_FETCH;
                        end
                        timeState         <= TS_READ;
                        i_core.startValid <= 1'b1;
                    end else if (cmdTaken) begin
                        case (i_cmdCode)
                            CMD_LOAD_ADDRESS: begin
                                pc <= i_switchReg;
                                ma <= i_switchReg;
                            end
                            CMD_DEPOSIT, CMD_EXAMINE: begin
                                ma                <= pc;
                                pc                <= pc + 1'b1;   // console auto-advance
                                majorState        <= (i_cmdCode == CMD_DEPOSIT) ? MS_DEPOSIT
                                                                                : MS_EXAMINE;
                                timeState         <= TS_READ;
                                i_core.startValid <= 1'b1;
                            end
                            CMD_START: begin
                                acc        <= '0;
                                link       <= 1'b0;
                                majorState <= MS_START;
                                run        <= 1'b1;
                            end
                            CMD_CONTINUE: run <= 1'b1;   // resume in current major state
                            default: ;
                        endcase
                    end
                end
                TS_READ: begin
                    if (i_core.startValid & i_core.startReady) i_core.startValid <= 1'b0;
                    if (i_core.readValid) begin
                        mb        <= i_core.readData;
                        timeState <= TS_MODIFY;
                    end
                end
                ////////////////////////////////////////
                // modify MB before writeback
                TS_MODIFY: begin
                    case (majorState)
                        MS_FETCH:   instruction <= mb;
                        MS_DEFER:   if (autoIndex) mb <= mb + 1'b1;   // 0010..0017
                        MS_EXEC: begin
                            case (opcode)
                                OP_ISZ:  mb <= mb + 1'b1;
                                OP_DCA:  mb <= acc;
                                OP_JMS:  mb <= pc;      // return address
                                default: ;
                            endcase
                        end
                        MS_DEPOSIT: mb <= switchLatch;
                        default: ;                      // examine writes back unchanged
                    endcase
                    i_core.writeValid <= 1'b1;
                    timeState         <= TS_WRITE;
                end
                TS_WRITE: if (i_core.writeDone) begin
                    i_core.writeValid <= 1'b0;
                    timeState         <= TS_FINISH;
                end
                ////////////////////////////////////////
                // finish picks the next major state
                default: begin
                    timeState  <= TS_IDLE;
                    majorState <= MS_START;
                    case (majorState)
                        MS_FETCH: begin
                            case (opcode)
                                OP_JMP: begin
                                    if (instruction[8]) begin
                                        ma         <= effAddr;
                                        majorState <= MS_DEFER;
                                    end else begin
                                        pc <= effAddr;   // direct jump
                                    end
                                end
                                OP_IOT: ;                // nothing attached, next fetch follows
                                OP_OPR: begin
                                    acc  <= i_oprAcc;
                                    link <= i_oprLink;
                                    pc   <= nextPc;      // skip adds one
                                    if (isHalt) begin
                                        run <= 1'b0;
                                        ma  <= nextPc;
                                    end
                                end
                                default: begin           // AND TAD ISZ DCA JMS
                                    ma         <= effAddr;
                                    majorState <= instruction[8] ? MS_DEFER : MS_EXEC;
                                end
                            endcase
                        end
                        MS_DEFER: begin
                            if (opcode == OP_JMP) begin
                                pc <= mb;                // indirect jump target
                            end else begin
                                ma         <= mb;
                                majorState <= MS_EXEC;
                            end
                        end
                        MS_EXEC: begin
                            case (opcode)
                                OP_AND, OP_TAD: begin
                                    acc  <= i_memRefAcc;
                                    link <= i_memRefLink;
                                end
                                OP_ISZ:  if (mb == '0) pc <= pc + 1'b1;
                                OP_DCA:  acc <= '0;
                                OP_JMS:  pc <= ma + 1'b1;   // continue after stored return
                                default: ;
                            endcase
                        end
                        default: ;                   // console cycles end here
                    endcase
                end
            endcase
        end
    end

    // memory request only pending within the read step
    assert property (@(posedge CLOCK) disable iff (RESET)
        i_core.startValid |-> timeState == TS_READ)
        else $error("startValid high outside TS_READ");

    // console ready only while halted with the memory idle
    assert property (@(posedge CLOCK) disable iff (RESET)
        o_cmdReady |-> !o_run && i_core.startReady)
        else $error("o_cmdReady high while running or memory busy");

endmodule

`default_nettype wire

// File: rtl/operateUnit.sv
/* combinational operate and AND/TAD logic, zero latency
   group 3 (EAE) words leave AC and link unchanged */
`timescale 1ns/1ps
`default_nettype none

module operateUnit (
    input  pdp8Package::word_t i_instruction,
    input  pdp8Package::word_t i_acc,
    input  pdp8Package::word_t i_memData,
    input  pdp8Package::word_t i_switchReg,
    input  logic               i_link,
    output pdp8Package::word_t o_oprAcc,
    output pdp8Package::word_t o_memRefAcc,
    output logic               o_oprLink,
    output logic               o_memRefLink,
    output logic               o_skip
);
    import pdp8Package::*;

    word_t g1Acc, rotAcc, g2Acc, tadSum;
    logic  g1Link, rotLink, g2Skip, tadCarry;
    logic  group1, group2;

    assign group1 = ~i_instruction[8];
    assign group2 = i_instruction[8] & ~i_instruction[0];

    ////////////////////////////////////////
    // group 1

    always_comb begin
        g1Acc  = i_instruction[7] ? '0 : i_acc;       // CLA
        g1Link = i_instruction[6] ? 1'b0 : i_link;    // CLL
        g1Acc  = i_instruction[5] ? ~g1Acc : g1Acc;   // CMA
        g1Link = g1Link ^ i_instruction[4];           // CML
        {g1Link, g1Acc} = {g1Link, g1Acc} + 13'(i_instruction[0]);   // IAC carries into link
        case (i_instruction[3:1])
            3'b001:  {rotLink, rotAcc} = {g1Link, g1Acc[5:0], g1Acc[11:6]};      // BSW
            3'b010:  {rotLink, rotAcc} = {g1Acc, g1Link};                        // RAL
            3'b011:  {rotLink, rotAcc} = {g1Acc[10:0], g1Link, g1Acc[11]};       // RTL
            3'b100:  {rotLink, rotAcc} = {g1Acc[0], g1Link, g1Acc[11:1]};        // RAR
            3'b101:  {rotLink, rotAcc} = {g1Acc[1:0], g1Link, g1Acc[11:2]};      // RTR
            default: {rotLink, rotAcc} = {g1Link, g1Acc};   // both directions, no rotate
        endcase
    end

    // group 2, skip sense flipped by bit 3
    assign g2Skip = ((i_instruction[6] & i_acc[11])
                   | (i_instruction[5] & (i_acc == '0))
                   | (i_instruction[4] & i_link)) ^ i_instruction[3];
    assign g2Acc  = (i_instruction[7] ? '0 : i_acc)
                  | (i_instruction[2] ? i_switchReg : '0);   // CLA then OSR

    assign o_oprAcc  = group1 ? rotAcc : (group2 ? g2Acc : i_acc);
    assign o_oprLink = group1 ? rotLink : i_link;
    assign o_skip    = group2 & g2Skip;

    ////////////////////////////////////////
    // memory reference arithmetic

    assign {tadCarry, tadSum} = {1'b0, i_acc} + {1'b0, i_memData};

    always_comb begin
        o_memRefAcc  = i_acc;
        o_memRefLink = i_link;
        case (opcode_e'(i_instruction[11:9]))
            OP_AND: o_memRefAcc = i_acc & i_memData;
            OP_TAD: begin
                o_memRefAcc  = tadSum;
                o_memRefLink = i_link ^ tadCarry;   // carry out flips link
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/coreMemory.sv
/* 4096-word local core with fixed read and write latency
   contents are not initialized, deposit before running */
`timescale 1ns/1ps
`default_nettype none

module coreMemory (
    input  logic        CLOCK,
    input  logic        RESET,
    coreCycleIf.memory  i_core
);
    import pdp8Package::*;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_READ,
        MEM_WAIT,    // read half done, waiting for writeValid
        MEM_WRITE
    } memPhase_e;

    word_t                    core [CORE_DEPTH];
    word_t                    addressReg;        // held for the whole cycle
    memPhase_e                phase;
    logic [LATENCY_WIDTH-1:0] count;
    logic                     accept, readFire, writeFire;

    assign i_core.startReady = (phase == MEM_IDLE);
    assign accept    = i_core.startValid & i_core.startReady;
    assign readFire  = (phase == MEM_READ) & (count == 1);
    assign writeFire = (phase == MEM_WRITE) & (count == 1);

    ////////////////////////////////////////
    // cycle control

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            phase            <= MEM_IDLE;
            count            <= '0;
            i_core.readValid <= 1'b0;
            i_core.writeDone <= 1'b0;
        end else begin
            i_core.readValid <= readFire;     // single clock pulses
            i_core.writeDone <= writeFire;
            case (phase)
                MEM_IDLE: if (accept) begin
                    phase <= MEM_READ;
                    count <= LATENCY_WIDTH'(READ_CYCLES);
                end
                MEM_READ: begin
                    count <= count - 1'b1;
                    if (readFire) phase <= MEM_WAIT;
                end
                MEM_WAIT: if (i_core.writeValid) begin
                    phase <= MEM_WRITE;
                    count <= LATENCY_WIDTH'(WRITE_CYCLES - 1);  // first clock seen already
                end
                default: begin
                    count <= count - 1'b1;
                    if (writeFire) phase <= MEM_IDLE;
                end
            endcase
        end
    end

    // array and data path
    always_ff @(posedge CLOCK) begin
        if (accept) addressReg <= i_core.address;
        if (readFire) i_core.readData <= core[addressReg];
        if (writeFire) core[addressReg] <= i_core.writeData;   // writeback half
    end

    // writeback only after the read half of this cycle returned
    assert property (@(posedge CLOCK) disable iff (RESET)
        $rose(i_core.writeValid) |-> phase == MEM_WAIT)
        else $error("writeValid rose before readValid of the cycle");

    // sequencer drops its request once accepted
    assert property (@(posedge CLOCK) disable iff (RESET)
        !i_core.startReady |-> !i_core.startValid)
        else $error("startValid held while memory busy");

endmodule

`default_nettype wire

// File: rtl/coreCycleIf.sv
/* one read-modify-write core cycle, only one in flight at a time
   writeData and writeValid are held until writeDone */
`timescale 1ns/1ps
`default_nettype none

interface coreCycleIf;
    import pdp8Package::*;

    logic  startValid;   // sequencer requests a cycle at address
    logic  startReady;   // memory idle, low until writeDone
    word_t address;
    word_t readData;
    logic  readValid;    // one clock pulse with readData
    word_t writeData;
    logic  writeValid;
    logic  writeDone;    // one clock pulse, word stored

    modport sequencer (
        output startValid, address, writeData, writeValid,
        input  startReady, readData, readValid, writeDone
    );

    modport memory (
        input  startValid, address, writeData, writeValid,
        output startReady, readData, readValid, writeDone
    );

endinterface

`default_nettype wire

// File: rtl/pdp8Package.sv
/* shared types and constants for the PDP-8/L-like core
   memory latencies are in CLOCK cycles and must fit in LATENCY_WIDTH bits */
`default_nettype none

package pdp8Package;

    localparam int WORD_WIDTH    = 12;     // data and address width
    localparam int CORE_DEPTH    = 4096;   // words of local core
    localparam int READ_CYCLES   = 4;      // accepted start to read data
    localparam int WRITE_CYCLES  = 3;      // writeValid to writeDone, at least 2
    localparam int LATENCY_WIDTH = 3;      // memory latency counter width

    typedef logic [WORD_WIDTH-1:0] word_t;

    localparam word_t AUTO_INDEX_BASE = 12'o0010;   // eight words 0010..0017

    // major state, which kind of memory cycle runs next
    typedef enum logic [2:0] {
        MS_START,
        MS_FETCH,
        MS_DEFER,
        MS_EXEC,
        MS_DEPOSIT,
        MS_EXAMINE
    } majorState_e;

    // time state, position within one read-modify-write cycle
    typedef enum logic [2:0] {
        TS_IDLE,
        TS_READ,
        TS_MODIFY,
        TS_WRITE,
        TS_FINISH
    } timeState_e;

    // instruction register bits 11:9
    typedef enum logic [2:0] {
        OP_AND = 3'd0,
        OP_TAD = 3'd1,
        OP_ISZ = 3'd2,
        OP_DCA = 3'd3,
        OP_JMS = 3'd4,
        OP_JMP = 3'd5,
        OP_IOT = 3'd6,
        OP_OPR = 3'd7
    } opcode_e;

    // console commands, accepted only while halted
    typedef enum logic [2:0] {
        CMD_LOAD_ADDRESS,
        CMD_DEPOSIT,
        CMD_EXAMINE,
        CMD_START,
        CMD_CONTINUE
    } consoleCmd_e;

endpackage

`default_nettype wire
